/* all.f */
src/mlpPkg.sv
src/featureLoader.sv
src/neuronNode.sv
src/denseLayer.sv
src/argMaxSelect.sv
src/mlpTop.sv
bench/mlpTb.sv

/* bench/mlpTb.sv */
`timescale 1ns/1ps

module mlpTb;
	localparam int featureCount = mlpPkg::featureCount;
	localparam int hiddenCount = mlpPkg::hiddenCount;
	localparam int classCount = mlpPkg::classCount;
	localparam int clockPeriod = 10;
	localparam int resultLatency = 8;
	localparam int randomFrames = 40;
	localparam int burstFrames = 6;
	localparam int frameTotal = randomFrames + burstFrames + 4; // extremes, abort, zero.
	localparam int slotCycles = 18; // one frame with every byte gap taken.
	localparam int watchdogCycles = frameTotal * slotCycles + 100;

	typedef logic [featureCount-1:0][7:0] featureFrame;
	typedef logic [classCount-1:0][7:0] scoreSet;

	logic clk;
	logic reset;
	logic byteValid;
	logic signed [7:0] byteData;
	logic frameAbort;
	logic resultValid;
	logic [$clog2(classCount)-1:0] classIndex;
	logic [7:0] classScore;
	scoreSet classScores;

	integer seed = 32'h7336;
	int cycleCount = 0;
	scoreSet scoreQueue[$];
	int indexQueue[$];
	int sentQueue[$]; // cycle of each frame's last byte.

	mlpTop i_mlpTop
	(
		.clk(clk),
		.reset(reset),
		.byteValid(byteValid),
		.byteData(byteData),
		.frameAbort(frameAbort),
		.resultValid(resultValid),
		.classIndex(classIndex),
		.classScore(classScore),
		.classScores(classScores)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clockPeriod / 2) clk = ~clk;
	end

	always @(posedge clk)
		cycleCount <= cycleCount + 1;

	// relu, divide by 64 with rounding, clip at 127.
	function automatic int squeeze(input int sum);
		int scaled;
		if (sum < 0)
			return 0;
		scaled = sum / 64;
		if (sum % 64 > 32)
			scaled++;
		return (scaled > 127) ? 127 : scaled;
	endfunction

	function automatic scoreSet referenceScores(input featureFrame frame);
		int hidden[hiddenCount];
		int sum;
		scoreSet scores;
		for (int n = 0; n < hiddenCount; n++)
		begin
			sum = int'($signed(mlpPkg::hiddenBias[n]));
			for (int i = 0; i < featureCount; i++)
				sum += int'($signed(frame[i]))
					* int'($signed(mlpPkg::hiddenWeights[n * featureCount + i]));
			hidden[n] = squeeze(sum);
		end
		for (int c = 0; c < classCount; c++)
		begin
			sum = int'($signed(mlpPkg::outputBias[c]));
			for (int h = 0; h < hiddenCount; h++)
				sum += hidden[h] * int'($signed(mlpPkg::outputWeights[c * hiddenCount + h]));
			scores[c] = 8'(squeeze(sum));
		end
		return scores;
	endfunction

	function automatic int referenceIndex(input scoreSet scores);
		int best;
		best = 0;
		for (int c = 1; c < classCount; c++)
			if (scores[c] > scores[best])
				best = c; // ties stay with the lower index.
		return best;
	endfunction

	function automatic featureFrame randomFrame();
		featureFrame frame;
		for (int i = 0; i < featureCount; i++)
			frame[i] = 8'($random(seed));
		return frame;
	endfunction

	task automatic reportFailure(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
			reportFailure($sformatf("mismatch %s: got %h, expected %h", name, actual, expected));
	endtask

	task automatic nextCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic expectResult(input featureFrame frame);
		scoreSet scores;
		scores = referenceScores(frame);
		scoreQueue.push_back(scores);
		indexQueue.push_back(referenceIndex(scores));
		sentQueue.push_back(cycleCount);
	endtask

	task automatic sendFrame(input featureFrame frame, input bit withGaps);
		for (int i = 0; i < featureCount; i++)
		begin
			if (withGaps && ($random(seed) % 2) != 0)
			begin
				byteValid = 1'b0;
				nextCycle();
			end
			byteValid = 1'b1;
			byteData = frame[i];
			if (i == featureCount - 1)
				expectResult(frame);
			nextCycle();
		end
		byteValid = 1'b0;
	endtask

	initial
	begin : stimulus
		featureFrame frame;
		reset = 1'b1;
		byteValid = 1'b0;
		byteData = '0;
		frameAbort = 1'b0;
		repeat (2) @(posedge clk);
		#1 reset = 1'b0;

		// idle outputs before any frame.
		repeat (10)
		begin
			@(negedge clk);
			checkValue("resultValid", 32'(resultValid), 0);
			checkValue("classScores", 32'(classScores), 0);
			checkValue("classIndex", 32'(classIndex), 0);
			checkValue("classScore", 32'(classScore), 0);
		end
		nextCycle();

		for (int f = 0; f < randomFrames; f++)
		begin
			sendFrame(randomFrame(), 1'b1);
			nextCycle();
		end

		frame = {featureCount{8'sd127}}; // saturation.
		sendFrame(frame, 1'b0);
		repeat (2) nextCycle();
		frame = {featureCount{8'h80}};
		sendFrame(frame, 1'b0);
		repeat (2) nextCycle();

		for (int f = 0; f < burstFrames; f++)
			sendFrame(randomFrame(), 1'b0); // no gaps, frames overlap.
		repeat (2) nextCycle();

		for (int i = 0; i < 3; i++)
		begin
			byteValid = 1'b1;
			byteData = 8'($random(seed));
			nextCycle();
		end
		byteValid = 1'b0;
		frameAbort = 1'b1;
		nextCycle();
		frameAbort = 1'b0;
		sendFrame(randomFrame(), 1'b0);
		repeat (2) nextCycle();

		// negative output biases give zero scores, tie goes to class 0.
		frame = '0;
		sendFrame(frame, 1'b0);

		repeat (resultLatency + 4) nextCycle();
		if (scoreQueue.size() != 0)
			reportFailure($sformatf("missing result for %0d frames", scoreQueue.size()));
		else
		begin
			// zero frame result still held at the outputs.
			checkValue("classScores", 32'(classScores), 0);
			checkValue("classIndex", 32'(classIndex), 0);
			checkValue("classScore", 32'(classScore), 0);
			$display("all tests passed");
			$finish;
		end
	end

	always @(negedge clk)
	begin : compare
		scoreSet expected;
		int expectedIndex;
		int sentCycle;
		if (!reset && resultValid)
		begin
			if (scoreQueue.size() == 0)
				reportFailure("unexpected result with no frame pending");
			else
			begin
				expected = scoreQueue.pop_front();
				expectedIndex = indexQueue.pop_front();
				sentCycle = sentQueue.pop_front();
				checkValue("classScores", 32'(classScores), 32'(expected));
				checkValue("classIndex", 32'(classIndex), 32'(expectedIndex));
				checkValue("classScore", 32'(classScore), 32'(expected[expectedIndex]));
				checkValue("result latency", 32'(cycleCount - sentCycle), resultLatency);
			end
		end
	end

	initial
	begin : watchdog
		#(watchdogCycles * clockPeriod);
		reportFailure($sformatf("timeout after %0d cycles", watchdogCycles));
	end

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module mlpTb -o mlpSim \
	&& ./obj_dir/mlpSim | tee /dev/stderr | grep -qx "all tests passed" \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

/* src/argMaxSelect.sv */
`timescale 1ns/1ps

module argMaxSelect
#(
	parameter int classNum = 3,
	localparam int indexWidth = $clog2(classNum)
)
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input logic [classNum-1:0][mlpPkg::actWidth-1:0] scores,
	output logic resultValid,
	output logic [indexWidth-1:0] classIndex,
	output logic [mlpPkg::actWidth-1:0] classScore
);
	logic [indexWidth-1:0] bestIndex;
	logic [mlpPkg::actWidth-1:0] bestScore;

	always_comb
	begin
		bestIndex = '0;
		bestScore = scores[0];
		for (int i = 1; i < classNum; i++)
		begin
			if ($signed(scores[i]) > $signed(bestScore)) // strict, so a tie keeps the lower index.
			begin
				bestIndex = indexWidth'(i);
				bestScore = scores[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			resultValid <= 1'b0;
			classIndex <= '0;
			classScore <= '0;
		end
		else
		begin
			resultValid <= inValid;
			if (inValid)
			begin
				classIndex <= bestIndex;
				classScore <= bestScore;
			end
		end
	end

	indexRange: assert property (@(posedge clk) disable iff (reset) classIndex < classNum)
		else $error("class index %0d out of range", classIndex);

endmodule

/* src/denseLayer.sv */
`timescale 1ns/1ps

module denseLayer
#(
	parameter int inputCount = 8,
	parameter int nodeCount = 4,
	parameter logic [0:inputCount*nodeCount-1][mlpPkg::weightWidth-1:0] weights = '0,
	parameter logic [0:nodeCount-1][mlpPkg::biasWidth-1:0] biases = '0
)
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input logic [inputCount-1:0][mlpPkg::actWidth-1:0] layerIn,
	output logic [nodeCount-1:0][mlpPkg::actWidth-1:0] layerOut,
	output logic layerValid
);
	logic [2:0] validPipe; // one bit per neuron stage.

	for (genvar n = 0; n < nodeCount; n++)
	begin : node
		neuronNode
		#(
			.inputCount(inputCount),
			.weights(weights[n*inputCount +: inputCount]),
			.bias(biases[n])
		)
		i_neuronNode
		(
			.clk(clk),
			.reset(reset),
			.act(layerIn),
			.result(layerOut[n])
		);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			validPipe <= '0;
		else
			validPipe <= {validPipe[1:0], inValid};
	end

	assign layerValid = validPipe[2];

endmodule

/* src/featureLoader.sv */
`timescale 1ns/1ps

module featureLoader
(
	input logic clk,
	input logic reset,
	input logic byteValid,
	input logic frameAbort,
	input logic signed [mlpPkg::actWidth-1:0] byteData,
	output logic [mlpPkg::featureCount-1:0][mlpPkg::actWidth-1:0] frameData,
	output logic frameValid
);
	localparam int featureCount = mlpPkg::featureCount;
	localparam int countWidth = $clog2(featureCount + 1);

	mlpPkg::loaderState state;
	logic [countWidth-1:0] byteCount;
	logic [featureCount-1:0][mlpPkg::actWidth-1:0] shiftReg;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= mlpPkg::lsIdle;
			byteCount <= '0;
			shiftReg <= '0;
			frameData <= '0;
			frameValid <= 1'b0;
		end
		else
		begin
			frameValid <= 1'b0;
			if (frameAbort)
			begin
				state <= mlpPkg::lsIdle; // partial frame dropped.
				byteCount <= '0;
			end
			else if (byteValid)
			begin
				shiftReg <= {byteData, shiftReg[featureCount-1:1]}; // first byte ends at index 0.
				case (state)
					mlpPkg::lsIdle:
					begin
						state <= mlpPkg::lsFill;
						byteCount <= countWidth'(1);
					end
					mlpPkg::lsFill:
					begin
						if (byteCount == countWidth'(featureCount - 1))
						begin
							frameData <= {byteData, shiftReg[featureCount-1:1]};
							frameValid <= 1'b1;
							state <= mlpPkg::lsIdle;
							byteCount <= '0;
						end
						else
							byteCount <= byteCount + 1'b1;
					end
					default: state <= mlpPkg::lsIdle;
				endcase
			end
		end
	end

	countBound: assert property (@(posedge clk) disable iff (reset)
		byteCount < featureCount && (state == mlpPkg::lsIdle) == (byteCount == '0))
		else $error("loader count out of step with state");

endmodule

/* src/mlpPkg.sv */
package mlpPkg;

	parameter int featureCount = 8;
	parameter int hiddenCount = 4;
	parameter int classCount = 3;

	parameter int actWidth = 8;
	parameter int weightWidth = 8;
	parameter int biasWidth = 16;
	parameter int accWidth = 23;

	// row r, column c sits at index r*cols+c.
	parameter logic [0:hiddenCount*featureCount-1][weightWidth-1:0] hiddenWeights = {
		8'sd12, -8'sd7, 8'sd21, 8'sd14, -8'sd5, 8'sd19, 8'sd30, -8'sd3,
		-8'sd20, 8'sd14, 8'sd6, -8'sd11, 8'sd25, -8'sd8, 8'sd3, 8'sd17,
		8'sd8, 8'sd19, -8'sd26, 8'sd13, 8'sd2, -8'sd14, 8'sd10, 8'sd22,
		-8'sd25, -8'sd12, 8'sd16, 8'sd7, -8'sd29, 8'sd11, -8'sd18, 8'sd7
	};

	parameter logic [0:hiddenCount-1][biasWidth-1:0] hiddenBias = {
		16'sd64, -16'sd128, 16'sd200, -16'sd40
	};

	parameter logic [0:classCount*hiddenCount-1][weightWidth-1:0] outputWeights = {
		8'sd20, -8'sd10, 8'sd15, 8'sd8,
		-8'sd6, 8'sd24, 8'sd12, -8'sd14,
		8'sd11, 8'sd9, -8'sd18, 8'sd26
	};

	parameter logic [0:classCount-1][biasWidth-1:0] outputBias = {
		-16'sd100, -16'sd64, -16'sd300 // all below zero.
	};

	typedef enum logic {lsIdle, lsFill} loaderState;

endpackage

/* src/mlpTop.sv */
`timescale 1ns/1ps

module mlpTop
(
	input logic clk,
	input logic reset,
	input logic byteValid,
	input logic signed [mlpPkg::actWidth-1:0] byteData,
	input logic frameAbort,
	output logic resultValid,
	output logic [$clog2(mlpPkg::classCount)-1:0] classIndex,
	output logic [mlpPkg::actWidth-1:0] classScore,
	output logic [mlpPkg::classCount-1:0][mlpPkg::actWidth-1:0] classScores
);
	logic [mlpPkg::featureCount-1:0][mlpPkg::actWidth-1:0] frameData;
	logic frameValid;
	logic [mlpPkg::hiddenCount-1:0][mlpPkg::actWidth-1:0] hiddenOut;
	logic hiddenValid;
	logic scoresValid;

	featureLoader i_featureLoader
	(
		.clk(clk),
		.reset(reset),
		.byteValid(byteValid),
		.frameAbort(frameAbort),
		.byteData(byteData),
		.frameData(frameData),
		.frameValid(frameValid)
	);

	denseLayer
	#(
		.inputCount(mlpPkg::featureCount),
		.nodeCount(mlpPkg::hiddenCount),
		.weights(mlpPkg::hiddenWeights),
		.biases(mlpPkg::hiddenBias)
	)
	i_hiddenLayer
	(
		.clk(clk),
		.reset(reset),
		.inValid(frameValid),
		.layerIn(frameData),
		.layerOut(hiddenOut),
		.layerValid(hiddenValid)
	);

	denseLayer
	#(
		.inputCount(mlpPkg::hiddenCount),
		.nodeCount(mlpPkg::classCount),
		.weights(mlpPkg::outputWeights),
		.biases(mlpPkg::outputBias)
	)
	i_outputLayer
	(
		.clk(clk),
		.reset(reset),
		.inValid(hiddenValid),
		.layerIn(hiddenOut),
		.layerOut(classScores),
		.layerValid(scoresValid)
	);

	argMaxSelect #(.classNum(mlpPkg::classCount)) i_argMaxSelect
	(
		.clk(clk),
		.reset(reset),
		.inValid(scoresValid),
		.scores(classScores),
		.resultValid(resultValid),
		.classIndex(classIndex),
		.classScore(classScore)
	);

endmodule

/* src/neuronNode.sv */
`timescale 1ns/1ps

module neuronNode
#(
	parameter int inputCount = 8,
	parameter logic [0:inputCount-1][mlpPkg::weightWidth-1:0] weights = '0,
	parameter logic signed [mlpPkg::biasWidth-1:0] bias = '0
)
(
	input logic clk,
	input logic reset,
	input logic [inputCount-1:0][mlpPkg::actWidth-1:0] act,
	output logic [mlpPkg::actWidth-1:0] result
);
	localparam int actWidth = mlpPkg::actWidth;
	localparam int accWidth = mlpPkg::accWidth;
	localparam int fracBits = 6; // divide by 64.
	localparam logic [actWidth-1:0] maxAct = actWidth'(2 ** (actWidth - 1) - 1);

	logic [inputCount-1:0][actWidth-1:0] actReg;
	logic signed [accWidth-1:0] macSum;
	logic signed [accWidth-1:0] accSum;
	logic roundUp;
	logic [accWidth-fracBits-1:0] rounded;

	always_comb
	begin
		macSum = accWidth'(bias);
		for (int i = 0; i < inputCount; i++)
			macSum = macSum + accWidth'($signed(actReg[i]) * $signed(weights[i]));
	end

	// round up only past the half step.
	assign roundUp = accSum[fracBits-1] && (accSum[fracBits-2:0] != '0);
	assign rounded = {1'b0, accSum[accWidth-2:fracBits]} + (accWidth - fracBits)'(roundUp);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actReg <= '0;
			accSum <= '0;
			result <= '0;
		end
		else
		begin
			actReg <= act;
			accSum <= macSum;
			if (accSum[accWidth-1])
				result <= '0; // relu.
			else if (rounded > (accWidth - fracBits)'(maxAct))
				result <= maxAct;
			else
				result <= rounded[actWidth-1:0];
		end
	end

	activationRange: assert property (@(posedge clk) disable iff (reset) result <= maxAct)
		else $error("neuron output above %0d", maxAct);

endmodule
